/* common/upsize_pkg.sv */
// ****************************************
// Upsizer shared definitions
// Port widths, AXI write channel types and FSM encodings
// ****************************************

package upsize_pkg;

  // Narrow slave port and wide master port geometry
  localparam int unsigned SlvBytes   = 4;
  localparam int unsigned MstBytes   = 8;
  localparam int unsigned SlvMaxSize = 2;
  localparam int unsigned MstMaxSize = 3;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdWidth   = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [7:0]           len_t;
  typedef logic [2:0]           size_t;
  typedef logic [1:0]           resp_t;

  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  typedef enum logic [1:0] {
    BurstFixed = 2'b00,
    BurstIncr  = 2'b01,
    BurstWrap  = 2'b10
  } burst_e;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
    logic   modifiable;
  } aw_chan_t;

  typedef struct packed {
    logic [SlvBytes*8-1:0] data;
    logic [SlvBytes-1:0]   strb;
    logic                  last;
  } slv_w_t;

  typedef struct packed {
    logic [MstBytes*8-1:0] data;
    logic [MstBytes-1:0]   strb;
    logic                  last;
  } mst_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // How a write burst is handled
  typedef enum logic [1:0] {
    ModePass   = 2'b00,
    ModeUpsize = 2'b01,
    ModeError  = 2'b10
  } wr_mode_e;

  typedef enum logic [1:0] {
    StIdle = 2'b00,
    StAddr = 2'b01,
    StData = 2'b10
  } wr_state_e;

endpackage

/* filelist.f */
+incdir+tests
common/upsize_pkg.sv
src/b_resp_merge.sv
upsizer/aw_len_calc.sv
upsizer/w_lane_packer.sv
upsizer/wr_upsize_ctrl.sv
upsizer/dw_upsizer.sv
tests/tb_dw_upsizer.sv

/* src/b_resp_merge.sv */
// ****************************************
// Write response merge
// Forwards master B or answers WRAP bursts with SLVERR
// ****************************************

`timescale 1ns/1ps

module b_resp_merge (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                err_req_i,
  input  upsize_pkg::id_t     err_id_i,
  input  upsize_pkg::b_chan_t mst_b_i,
  input  logic                mst_b_valid_i,
  input  logic                slv_b_ready_i,
  output logic                mst_b_ready_o,
  output upsize_pkg::b_chan_t slv_b_o,
  output logic                slv_b_valid_o
);

  logic            err_pend_q;
  upsize_pkg::id_t err_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_pend_q <= 1'b0;
    end else if (err_req_i) begin
      err_pend_q <= 1'b1;
    end else if (slv_b_ready_i) begin
      err_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_req_i) begin
      err_id_q <= err_id_i;
    end
  end

  // Local error wins, master B waits behind it
  assign slv_b_valid_o = err_pend_q || mst_b_valid_i;
  assign slv_b_o       = err_pend_q ? '{id: err_id_q, resp: upsize_pkg::RespSlvErr} : mst_b_i;
  assign mst_b_ready_o = !err_pend_q && slv_b_ready_i;

endmodule

/* tests/tb_upsize_model.svh */
// ****************************************
// Upsizer reference model
// Expected master AW, wide W beats and B responses
// ****************************************

`ifndef TB_UPSIZE_MODEL_SVH
`define TB_UPSIZE_MODEL_SVH

upsize_pkg::aw_chan_t exp_aw[$];
upsize_pkg::mst_w_t   exp_w[$];
upsize_pkg::b_chan_t  exp_b[$];
logic [31:0]          beat_data [8];
logic [3:0]           beat_strb [8];

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s ^ (s << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Queues what the master port and the slave B channel should show for one burst
task automatic model_burst(input upsize_pkg::aw_chan_t aw, output string kind);
  upsize_pkg::aw_chan_t wide_aw;
  upsize_pkg::mst_w_t   word;
  upsize_pkg::b_chan_t  b;
  logic [31:0]          addr;
  logic [31:0]          next;
  logic                 upsize;
  int                   off_s;
  int                   off_w;
  int                   words;
  upsize = (aw.burst == upsize_pkg::BurstIncr) && aw.modifiable && (aw.len != 0);
  b.id   = aw.id;
  if ((aw.burst == upsize_pkg::BurstWrap) && (aw.len != 0)) begin
    kind   = "wrap_error";
    b.resp = upsize_pkg::RespSlvErr;
  end else begin
    kind   = upsize ? "upsize" : "pass";
    b.resp = upsize_pkg::RespOkay;
    word   = '0;
    addr   = aw.addr;
    words  = 0;
    for (int i = 0; i <= aw.len; i++) begin
      off_s = int'(addr[1:0]);
      off_w = int'(addr[2:0]);
      for (int n = 0; n < 4; n++) begin
        if ((n >= off_s) && ((n - off_s) < (1 << aw.size))) begin
          word.data[8*(n+off_w-off_s) +: 8] = beat_data[i][8*n +: 8];
          word.strb[n+off_w-off_s]          = beat_strb[i][n];
        end
      end
      next      = (aw.burst == upsize_pkg::BurstIncr) ?
                  (((addr >> aw.size) + 1) << aw.size) : addr;
      word.last = (i == aw.len);
      if (!upsize || word.last || ((next >> 3) != (addr >> 3))) begin
        exp_w.push_back(word);
        word  = '0;
        words = words + 1;
      end
      addr = next;
    end
    wide_aw = aw;
    if (upsize) begin
      wide_aw.len  = upsize_pkg::len_t'(words - 1);
      wide_aw.size = upsize_pkg::size_t'(upsize_pkg::MstMaxSize);
    end
    exp_aw.push_back(wide_aw);
  end
  exp_b.push_back(b);
endtask

`endif

/* tests/tb_dw_upsizer.sv */
// ****************************************
// Testbench for the AXI write upsizer
// Random bursts checked against a reference model
// ****************************************

`timescale 1ns/1ps

module tb_dw_upsizer;

  localparam int NumBursts = 60;
  localparam int ClkPeriod = 4;
  localparam logic [31:0] Seed = 32'hb9635ce1;

  logic clk = 1'b0;
  logic rst_n;
  upsize_pkg::aw_chan_t slv_aw, mst_aw, aw_seen;
  upsize_pkg::slv_w_t   slv_w;
  upsize_pkg::mst_w_t   mst_w, w_seen;
  upsize_pkg::b_chan_t  slv_b, mst_b, b_seen;
  logic slv_aw_valid, slv_aw_ready, slv_w_valid, slv_w_ready, slv_b_valid, slv_b_ready;
  logic mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready, mst_b_valid, mst_b_ready;
  logic [31:0] stim_rng = Seed;
  logic [31:0] stall_rng = ~Seed;
  upsize_pkg::id_t b_ids[$];
  upsize_pkg::id_t cur_id;
  logic  mb_taken = 1'b0;
  int    errors = 0;
  int    tests = 0;
  int    failed = 0;
  int    b_count = 0;
  string test_name = "startup";

  `include "tb_upsize_model.svh"

  dw_upsizer dut_i (
    .clk_i (clk), .rst_ni (rst_n),
    .slv_aw_i (slv_aw), .slv_aw_valid_i (slv_aw_valid), .slv_aw_ready_o (slv_aw_ready),
    .slv_w_i (slv_w), .slv_w_valid_i (slv_w_valid), .slv_w_ready_o (slv_w_ready),
    .slv_b_o (slv_b), .slv_b_valid_o (slv_b_valid), .slv_b_ready_i (slv_b_ready),
    .mst_aw_o (mst_aw), .mst_aw_valid_o (mst_aw_valid), .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o (mst_w), .mst_w_valid_o (mst_w_valid), .mst_w_ready_i (mst_w_ready),
    .mst_b_i (mst_b), .mst_b_valid_i (mst_b_valid), .mst_b_ready_o (mst_b_ready)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  task automatic report_mismatch(input string what, input logic [72:0] expv,
                                 input logic [72:0] actv);
    errors++;
    $display("Mismatch %s %s: expected %h actual %h", test_name, what, expv, actv);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic finish_test(input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("%s: PASS", test_name);
    end else begin
      failed++;
      $display("%s: FAIL", test_name);
    end
  endtask

  // Master port model with random ready stalls and one OKAY B per last wide beat
  always @(posedge clk) begin
    #1;
    stall_rng    = xorshift(stall_rng);
    mst_aw_ready = |stall_rng[1:0];
    mst_w_ready  = |stall_rng[3:2];
    slv_b_ready  = |stall_rng[5:4];
    if (mb_taken) begin
      mst_b_valid = 1'b0;
      mb_taken    = 1'b0;
    end
    if (!mst_b_valid && (b_ids.size() > 0)) begin
      mst_b.id    = b_ids.pop_front();
      mst_b.resp  = upsize_pkg::RespOkay;
      mst_b_valid = 1'b1;
    end
  end

  // Handshakes are sampled mid-cycle where valid and ready are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (mst_aw_valid && mst_aw_ready) begin
        if (exp_aw.size() == 0) begin
          report_error("AW appeared on the master port with none expected");
        end else begin
          aw_seen = exp_aw.pop_front();
          if (mst_aw !== aw_seen) report_mismatch("master AW", aw_seen, mst_aw);
        end
        cur_id = mst_aw.id;
      end
      if (mst_w_valid && mst_w_ready) begin
        if (exp_w.size() == 0) begin
          report_error("wide W beat appeared with none expected");
        end else begin
          w_seen = exp_w.pop_front();
          if (mst_w !== w_seen) report_mismatch("wide W beat", w_seen, mst_w);
        end
        if (mst_w.last) b_ids.push_back(cur_id);
      end
      if (mst_b_valid && mst_b_ready) mb_taken = 1'b1;
      if (slv_b_valid && slv_b_ready) begin
        if (exp_b.size() == 0) begin
          report_error("B response appeared with none expected");
        end else begin
          b_seen = exp_b.pop_front();
          if (slv_b !== b_seen) report_mismatch("slave B", b_seen, slv_b);
        end
        b_count++;
      end
    end
  end

  task automatic run_burst(input int t);
    upsize_pkg::aw_chan_t aw;
    logic [31:0] r;
    string kind;
    int err_before;
    int b_before;
    err_before    = errors;
    r             = next_rand();
    aw.burst      = (r[1:0] == 2'd0) ? upsize_pkg::BurstFixed :
                    (r[1:0] == 2'd3) ? upsize_pkg::BurstWrap : upsize_pkg::BurstIncr;
    aw.modifiable = r[2] | r[3];
    aw.len        = upsize_pkg::len_t'(r[6:4]);
    aw.size       = (r[9:8] == 2'd3) ? 3'd2 : {1'b0, r[9:8]};
    aw.id         = r[13:10];
    r             = next_rand();
    aw.addr       = ((r & 32'h0000_ffff) >> aw.size) << aw.size;
    for (int i = 0; i <= aw.len; i++) begin
      beat_data[i] = next_rand();
      r            = next_rand();
      beat_strb[i] = r[3:0];
    end
    model_burst(aw, kind);
    test_name = $sformatf("burst%0d_%s", t, kind);
    b_before  = b_count;
    slv_aw       = aw;
    slv_aw_valid = 1'b1;
    @(negedge clk);
    while (!slv_aw_ready) @(negedge clk);
    @(posedge clk);
    #1 slv_aw_valid = 1'b0;
    for (int i = 0; i <= aw.len; i++) begin
      r = next_rand();
      if (r[0] & r[1]) begin
        // Idle cycle on the narrow W channel
        @(posedge clk);
        #1;
      end
      slv_w.data  = beat_data[i];
      slv_w.strb  = beat_strb[i];
      slv_w.last  = (i == aw.len);
      slv_w_valid = 1'b1;
      @(negedge clk);
      while (!slv_w_ready) @(negedge clk);
      @(posedge clk);
      #1 slv_w_valid = 1'b0;
    end
    // B count moves at the falling edge and is read at the rising edge
    while (b_count == b_before) @(posedge clk);
    #1;
    if ((exp_aw.size() != 0) || (exp_w.size() != 0) || (exp_b.size() != 0)) begin
      report_error("expected master traffic never arrived");
    end
    finish_test(err_before);
  endtask

  initial begin
    int err_before;
    slv_aw       = '0;
    slv_aw_valid = 1'b0;
    slv_w        = '0;
    slv_w_valid  = 1'b0;
    slv_b_ready  = 1'b0;
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b        = '0;
    mst_b_valid  = 1'b0;
    rst_n        = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    test_name  = "reset_state";
    err_before = errors;
    if (!slv_aw_ready || mst_aw_valid || mst_w_valid || slv_w_ready || slv_b_valid) begin
      report_error("control outputs not at their reset values");
    end
    finish_test(err_before);
    @(posedge clk);
    #1;
    for (int t = 0; t < NumBursts; t++) begin
      run_burst(t);
    end
    $display("Tests: %0d run, %0d passed, %0d failed, %0d check errors",
             tests, tests - failed, failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the burst count
  initial begin
    #(NumBursts * 200 * ClkPeriod);
    $display("Timeout: run did not finish within %0d cycles", NumBursts * 200);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* upsizer/aw_len_calc.sv */
// ****************************************
// AW rewrite for the wide port
// Computes the upsized length and the burst mode
// ****************************************

`timescale 1ns/1ps

module aw_len_calc (
  input  upsize_pkg::aw_chan_t aw_i,
  output upsize_pkg::aw_chan_t aw_o,
  output upsize_pkg::wr_mode_e mode_o
);

  upsize_pkg::addr_t size_mask;
  upsize_pkg::addr_t last_addr;
  upsize_pkg::addr_t word_mask;
  upsize_pkg::addr_t span;

  // Address of the final narrow beat of an INCR burst
  assign size_mask = ~((upsize_pkg::addr_t'(1) << aw_i.size) - 1);
  assign last_addr = (aw_i.addr & size_mask) +
                     (upsize_pkg::addr_t'(aw_i.len) << aw_i.size);

  // Distance in wide words between first and last beat
  assign word_mask = ~((upsize_pkg::addr_t'(1) << upsize_pkg::MstMaxSize) - 1);
  assign span      = ((last_addr & word_mask) - (aw_i.addr & word_mask)) >>
                     upsize_pkg::MstMaxSize;

  always_comb begin
    aw_o   = aw_i;
    mode_o = upsize_pkg::ModePass;
    case (aw_i.burst)
      upsize_pkg::BurstIncr: begin
        if (aw_i.modifiable && (aw_i.len != '0)) begin
          aw_o.len  = upsize_pkg::len_t'(span);
          aw_o.size = upsize_pkg::size_t'(upsize_pkg::MstMaxSize);
          mode_o    = upsize_pkg::ModeUpsize;
        end
      end
      upsize_pkg::BurstWrap: begin
        // Single-beat WRAP is harmless and passes
        if (aw_i.len != '0) begin
          mode_o = upsize_pkg::ModeError;
        end
      end
      default: mode_o = upsize_pkg::ModePass;
    endcase
  end

endmodule

/* upsizer/dw_upsizer.sv */
// ****************************************
// AXI write data-width upsizer
// Joins a 32-bit slave port to a 64-bit master port
// ****************************************

`timescale 1ns/1ps

module dw_upsizer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Slave side
  input  upsize_pkg::aw_chan_t slv_aw_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  upsize_pkg::slv_w_t   slv_w_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  output upsize_pkg::b_chan_t  slv_b_o,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  // Master side
  output upsize_pkg::aw_chan_t mst_aw_o,
  output logic                 mst_aw_valid_o,
  input  logic                 mst_aw_ready_i,
  output upsize_pkg::mst_w_t   mst_w_o,
  output logic                 mst_w_valid_o,
  input  logic                 mst_w_ready_i,
  input  upsize_pkg::b_chan_t  mst_b_i,
  input  logic                 mst_b_valid_i,
  output logic                 mst_b_ready_o
);

  upsize_pkg::aw_chan_t calc_aw;
  upsize_pkg::wr_mode_e calc_mode;
  upsize_pkg::addr_t    beat_addr;
  upsize_pkg::size_t    beat_size;
  upsize_pkg::id_t      err_id;
  logic                 take;
  logic                 flush;
  logic                 last;
  logic                 buf_full;
  logic                 err_req;

  aw_len_calc calc_i (
    .aw_i   (slv_aw_i),
    .aw_o   (calc_aw),
    .mode_o (calc_mode)
  );

  wr_upsize_ctrl ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_valid_i (slv_aw_valid_i),
    .calc_aw_i      (calc_aw),
    .calc_mode_i    (calc_mode),
    .orig_len_i     (slv_aw_i.len),
    .orig_size_i    (slv_aw_i.size),
    .mst_aw_ready_i (mst_aw_ready_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_last_i   (slv_w_i.last),
    .buf_full_i     (buf_full),
    .mst_w_ready_i  (mst_w_ready_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .slv_w_ready_o  (slv_w_ready_o),
    .beat_addr_o    (beat_addr),
    .beat_size_o    (beat_size),
    .take_o         (take),
    .flush_o        (flush),
    .last_o         (last),
    .err_req_o      (err_req),
    .err_id_o       (err_id)
  );

  w_lane_packer packer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_w_i       (slv_w_i),
    .beat_addr_i   (beat_addr),
    .beat_size_i   (beat_size),
    .take_i        (take),
    .flush_i       (flush),
    .last_i        (last),
    .mst_w_ready_i (mst_w_ready_i),
    .mst_w_o       (mst_w_o),
    .mst_w_valid_o (mst_w_valid_o)
  );

  // The packer word valid doubles as its full flag
  assign buf_full = mst_w_valid_o;

  b_resp_merge bresp_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .err_req_i     (err_req),
    .err_id_i      (err_id),
    .mst_b_i       (mst_b_i),
    .mst_b_valid_i (mst_b_valid_i),
    .slv_b_ready_i (slv_b_ready_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_o       (slv_b_o),
    .slv_b_valid_o (slv_b_valid_o)
  );

endmodule

/* upsizer/w_lane_packer.sv */
// ****************************************
// W lane packer
// Steers narrow beats into the wide word register
// ****************************************

`timescale 1ns/1ps

module w_lane_packer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  upsize_pkg::slv_w_t slv_w_i,
  input  upsize_pkg::addr_t  beat_addr_i,
  input  upsize_pkg::size_t  beat_size_i,
  input  logic               take_i,
  input  logic               flush_i,
  input  logic               last_i,
  input  logic               mst_w_ready_i,
  output upsize_pkg::mst_w_t mst_w_o,
  output logic               mst_w_valid_o
);

  upsize_pkg::mst_w_t                   word_q, word_d;
  logic                                 valid_q, valid_d;
  logic [upsize_pkg::MstMaxSize-1:0]    off_m;
  logic [upsize_pkg::SlvMaxSize-1:0]    off_s;
  int                                   lane_shift;

  assign off_m      = beat_addr_i[upsize_pkg::MstMaxSize-1:0];
  assign off_s      = beat_addr_i[upsize_pkg::SlvMaxSize-1:0];
  assign lane_shift = int'(off_m) - int'(off_s);

  always_comb begin
    word_d  = word_q;
    valid_d = valid_q;

    // Accepted word is cleared so a new one starts with no strobes
    if (valid_q && mst_w_ready_i) begin
      word_d  = '0;
      valid_d = 1'b0;
    end

    if (take_i) begin
      for (int n = 0; n < upsize_pkg::SlvBytes; n++) begin
        // Only bytes inside the beat size, starting at the narrow offset
        if ((n >= int'(off_s)) && ((n - int'(off_s)) < (1 << beat_size_i))) begin
          word_d.data[8*(n+lane_shift) +: 8] = slv_w_i.data[8*n +: 8];
          word_d.strb[n+lane_shift]          = slv_w_i.strb[n];
        end
      end
      word_d.last = last_i;
      if (flush_i) begin
        valid_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      word_q  <= word_d;
      valid_q <= valid_d;
    end
  end

  assign mst_w_o       = word_q;
  assign mst_w_valid_o = valid_q;

endmodule

/* upsizer/wr_upsize_ctrl.sv */
// ****************************************
// Upsizer write controller
// Holds the burst, walks the narrow beat address and drives AW
// ****************************************

`timescale 1ns/1ps

module wr_upsize_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 slv_aw_valid_i,
  input  upsize_pkg::aw_chan_t calc_aw_i,
  input  upsize_pkg::wr_mode_e calc_mode_i,
  input  upsize_pkg::len_t     orig_len_i,
  input  upsize_pkg::size_t    orig_size_i,
  input  logic                 mst_aw_ready_i,
  input  logic                 slv_w_valid_i,
  input  logic                 slv_w_last_i,
  input  logic                 buf_full_i,
  input  logic                 mst_w_ready_i,
  output logic                 slv_aw_ready_o,
  output upsize_pkg::aw_chan_t mst_aw_o,
  output logic                 mst_aw_valid_o,
  output logic                 slv_w_ready_o,
  output upsize_pkg::addr_t    beat_addr_o,
  output upsize_pkg::size_t    beat_size_o,
  output logic                 take_o,
  output logic                 flush_o,
  output logic                 last_o,
  output logic                 err_req_o,
  output upsize_pkg::id_t      err_id_o
);

  upsize_pkg::wr_state_e state_q, state_d;
  upsize_pkg::wr_mode_e  mode_q;
  upsize_pkg::len_t      beats_q;
  logic                  done_q;
  upsize_pkg::aw_chan_t  aw_q;
  upsize_pkg::addr_t     addr_q;
  upsize_pkg::size_t     size_q;
  upsize_pkg::addr_t     next_addr;
  upsize_pkg::addr_t     size_mask;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  is_err;

  assign is_err = (mode_q == upsize_pkg::ModeError);

  assign slv_aw_ready_o = (state_q == upsize_pkg::StIdle);
  assign mst_aw_valid_o = (state_q == upsize_pkg::StAddr);
  assign mst_aw_o       = aw_q;

  // Error bursts are drained without waiting on the packer
  assign slv_w_ready_o = (state_q == upsize_pkg::StData) && !done_q &&
                         (is_err || !buf_full_i || mst_w_ready_i);

  assign aw_hs = slv_aw_valid_i && slv_aw_ready_o;
  assign w_hs  = slv_w_valid_i && slv_w_ready_o;

  assign take_o      = w_hs && !is_err;
  assign err_req_o   = w_hs && is_err && slv_w_last_i;
  assign err_id_o    = aw_q.id;
  assign beat_addr_o = addr_q;
  assign beat_size_o = size_q;
  assign last_o      = (beats_q == '0);

  // Next size-aligned address, FIXED bursts stay put
  assign size_mask = ~((upsize_pkg::addr_t'(1) << size_q) - 1);
  assign next_addr = (aw_q.burst == upsize_pkg::BurstIncr) ?
                     (addr_q & size_mask) + (upsize_pkg::addr_t'(1) << size_q) : addr_q;

  // Send the word on the last beat or when the next beat leaves this wide word
  assign flush_o = (mode_q != upsize_pkg::ModeUpsize) || last_o ||
                   (next_addr[upsize_pkg::AddrWidth-1:upsize_pkg::MstMaxSize] !=
                    addr_q[upsize_pkg::AddrWidth-1:upsize_pkg::MstMaxSize]);

  always_comb begin
    state_d = state_q;
    case (state_q)
      upsize_pkg::StIdle: begin
        if (aw_hs) begin
          state_d = (calc_mode_i == upsize_pkg::ModeError) ? upsize_pkg::StData :
                                                             upsize_pkg::StAddr;
        end
      end
      upsize_pkg::StAddr: begin
        if (mst_aw_ready_i) begin
          state_d = upsize_pkg::StData;
        end
      end
      upsize_pkg::StData: begin
        if (is_err) begin
          if (w_hs && slv_w_last_i) begin
            state_d = upsize_pkg::StIdle;
          end
        end else if (done_q && buf_full_i && mst_w_ready_i) begin
          // Final wide beat leaves the packer
          state_d = upsize_pkg::StIdle;
        end
      end
      default: state_d = upsize_pkg::StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= upsize_pkg::StIdle;
      mode_q  <= upsize_pkg::ModePass;
      beats_q <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (aw_hs) begin
        mode_q  <= calc_mode_i;
        beats_q <= orig_len_i;
        done_q  <= 1'b0;
      end else if (take_o) begin
        beats_q <= beats_q - 1'b1;
        done_q  <= last_o;
      end
    end
  end

  // Burst payload
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_q   <= calc_aw_i;
      addr_q <= calc_aw_i.addr;
      size_q <= orig_size_i;
    end else if (take_o) begin
      addr_q <= next_addr;
    end
  end

endmodule
